//--- data_bank.sv
`timescale 1ns/1ps

module data_bank #(
    parameter int LANE        = 0,
    parameter int DEPTH_WORDS = 256
) (
    input  logic   clk,
    input  logic   rst_n_i,
    dmem_if.bank   bus
);

    localparam int AW = $clog2(DEPTH_WORDS);

    mem_pkg::byte_t mem [DEPTH_WORDS];
    mem_pkg::byte_t rdata_q;
    logic           ack_q;
    logic [AW-1:0]  word_sel;
    logic           access;

    assign word_sel = bus.idx[AW-1:0];

    // first cycle of a request, the cycle after an ack never counts
    assign access = bus.req & ~ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // write and read share the edge that raises ack
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we && bus.wmask[LANE]) begin
                mem[word_sel] <= bus.wdata[LANE];
            end
            rdata_q <= mem[word_sel];
        end
    end

    assign bus.rdata[LANE] = rdata_q;
    assign bus.ack[LANE]   = ack_q;

endmodule

//--- dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;

    // request side, held for the whole access
    logic                            req;
    logic                            we;
    mem_pkg::bank_idx_t              idx;
    logic [mem_pkg::NUM_LANES-1:0]   wmask;
    mem_pkg::byte_t                  wdata [mem_pkg::NUM_LANES];

    // response side, one lane per bank
    mem_pkg::byte_t                  rdata [mem_pkg::NUM_LANES];
    logic [mem_pkg::NUM_LANES-1:0]   ack;

    modport stage (
        output req,
        output we,
        output idx,
        output wmask,
        output wdata,
        input  rdata,
        input  ack
    );

    modport bank (
        input  req,
        input  we,
        input  idx,
        input  wmask,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- flist.f
mem_pkg.sv
dmem_if.sv
data_bank.sv
mem_stage.sv
wb_stage.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

//--- mem_pkg.sv
package mem_pkg;

    // data path widths
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  reg_idx_t;

    // one bit per field, see bit positions below
    typedef logic [5:0]  mem_op_t;

    // word index into a bank, only the low bits reach the array
    typedef logic [31:0] bank_idx_t;

    // byte lanes, one bank per lane
    localparam int NUM_LANES = 4;

    // memory access flag
    localparam int MEM_OP_EN  = 0;

    // zero extend on load
    localparam int MEM_OP_UNS = 1;

    // store when set, load when clear
    localparam int MEM_OP_ST  = 2;

    // access size, exactly one of these is set for a memory item
    localparam int MEM_OP_W   = 3;
    localparam int MEM_OP_H   = 4;
    localparam int MEM_OP_B   = 5;

endpackage

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  mem_pkg::mem_op_t     in_op_i,
    input  mem_pkg::word_t       in_addr_i,
    input  mem_pkg::word_t       in_store_data_i,
    input  mem_pkg::word_t       in_pc_i,
    input  mem_pkg::reg_idx_t    in_wreg_idx_i,
    input  logic                 in_wreg_en_i,

    dmem_if.stage                dmem,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output mem_pkg::word_t       out_result_o,
    output mem_pkg::word_t       out_pc_o,
    output mem_pkg::reg_idx_t    out_wreg_idx_o,
    output logic                 out_wreg_en_o
);

    logic [1:0]                     offset;
    logic                           is_mem;
    logic                           is_load;
    logic [mem_pkg::NUM_LANES-1:0]  st_mask;
    mem_pkg::word_t                 st_data;
    mem_pkg::word_t                 rd_word;
    mem_pkg::byte_t                 rd_byte;
    logic [15:0]                    rd_half;
    mem_pkg::word_t                 load_val;
    logic                           ack_all;
    logic                           done_q;
    logic                           mem_done;
    logic                           space;
    logic                           accept;
    logic                           out_valid_q;
    mem_pkg::word_t                 result_q;
    mem_pkg::word_t                 pc_q;
    mem_pkg::reg_idx_t              wreg_idx_q;
    logic                           wreg_en_q;

    assign offset  = in_addr_i[1:0];
    assign is_mem  = in_op_i[mem_pkg::MEM_OP_EN];
    assign is_load = is_mem & ~in_op_i[mem_pkg::MEM_OP_ST];

    // store alignment, data is replicated so every lane sees its byte
    always_comb begin
        st_mask = '0;
        if (in_op_i[mem_pkg::MEM_OP_W]) begin
            st_mask = '1;
            st_data = in_store_data_i;
        end else if (in_op_i[mem_pkg::MEM_OP_H]) begin
            st_mask = offset[1] ? 4'b1100 : 4'b0011;
            st_data = {2{in_store_data_i[15:0]}};
        end else begin
            st_mask[offset] = 1'b1;
            st_data = {4{in_store_data_i[7:0]}};
        end
    end

    // bank request, dropped once the acks are in or on flush
    assign dmem.req   = in_valid_i & is_mem & ~done_q & ~flush_i;
    assign dmem.we    = in_op_i[mem_pkg::MEM_OP_ST];
    assign dmem.idx   = in_addr_i >> 2;
    assign dmem.wmask = st_mask;

    always_comb begin
        for (int i = 0; i < mem_pkg::NUM_LANES; i++) begin
            dmem.wdata[i]     = st_data[8*i +: 8];
            rd_word[8*i +: 8] = dmem.rdata[i];
        end
    end

    // load extraction by offset and size
    assign rd_byte = rd_word[{offset, 3'b000} +: 8];
    assign rd_half = offset[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        if (in_op_i[mem_pkg::MEM_OP_W]) begin
            load_val = rd_word;
        end else if (in_op_i[mem_pkg::MEM_OP_H]) begin
            load_val = in_op_i[mem_pkg::MEM_OP_UNS] ? {16'h0, rd_half}
                                                    : {{16{rd_half[15]}}, rd_half};
        end else begin
            load_val = in_op_i[mem_pkg::MEM_OP_UNS] ? {24'h0, rd_byte}
                                                    : {{24{rd_byte[7]}}, rd_byte};
        end
    end

    // all banks answer together, done_q remembers a finished access
    // while downstream is full so the banks see one request per item
    assign ack_all  = &dmem.ack;
    assign mem_done = ack_all | done_q;
    assign space    = ~out_valid_q | out_ready_i;

    // a flush consumes the incoming item without keeping it
    assign in_ready_o = flush_i | (space & (~is_mem | mem_done));
    assign accept     = in_valid_i & in_ready_o & ~flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            if (accept) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
            done_q <= in_valid_i & is_mem & mem_done & ~accept;
        end
    end

    // result register, alu items pass their address
    always_ff @(posedge clk) begin
        if (accept) begin
            result_q   <= is_load ? load_val : in_addr_i;
            pc_q       <= in_pc_i;
            wreg_idx_q <= in_wreg_idx_i;
            wreg_en_q  <= in_wreg_en_i;
        end
    end

    assign out_valid_o    = out_valid_q & ~flush_i;
    assign out_result_o   = result_q;
    assign out_pc_o       = pc_q;
    assign out_wreg_idx_o = wreg_idx_q;
    assign out_wreg_en_o  = wreg_en_q;

endmodule

//--- mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  mem_pkg::mem_op_t     in_op_i,
    input  mem_pkg::word_t       in_addr_i,
    input  mem_pkg::word_t       in_store_data_i,
    input  mem_pkg::word_t       in_pc_i,
    input  mem_pkg::reg_idx_t    in_wreg_idx_i,
    input  logic                 in_wreg_en_i,

    output logic                 wb_valid_o,
    input  logic                 wb_ready_i,
    output logic                 wb_we_o,
    output mem_pkg::reg_idx_t    wb_idx_o,
    output mem_pkg::word_t       wb_data_o,
    output mem_pkg::word_t       wb_pc_o
);

    // memory stage to writeback
    logic               ms_valid;
    logic               ms_ready;
    mem_pkg::word_t     ms_result;
    mem_pkg::word_t     ms_pc;
    mem_pkg::reg_idx_t  ms_wreg_idx;
    logic               ms_wreg_en;

    dmem_if u_dmem_if ();

    mem_stage u_mem_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .in_op_i         (in_op_i),
        .in_addr_i       (in_addr_i),
        .in_store_data_i (in_store_data_i),
        .in_pc_i         (in_pc_i),
        .in_wreg_idx_i   (in_wreg_idx_i),
        .in_wreg_en_i    (in_wreg_en_i),
        .dmem            (u_dmem_if.stage),
        .out_valid_o     (ms_valid),
        .out_ready_i     (ms_ready),
        .out_result_o    (ms_result),
        .out_pc_o        (ms_pc),
        .out_wreg_idx_o  (ms_wreg_idx),
        .out_wreg_en_o   (ms_wreg_en)
    );

    // one bank per byte lane
    for (genvar i = 0; i < mem_pkg::NUM_LANES; i++) begin : g_bank
        data_bank #(
            .LANE        (i),
            .DEPTH_WORDS (DEPTH_WORDS)
        ) u_data_bank (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .bus     (u_dmem_if.bank)
        );
    end

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (ms_valid),
        .in_ready_o    (ms_ready),
        .in_result_i   (ms_result),
        .in_pc_i       (ms_pc),
        .in_wreg_idx_i (ms_wreg_idx),
        .in_wreg_en_i  (ms_wreg_en),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_we_o       (wb_we_o),
        .wb_idx_o      (wb_idx_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o)
    );

endmodule

//--- run_sim.sh
#!/bin/bash
# build and run the memory subsystem testbench with Verilator
verilator --binary --timing --top-module tb_mem_subsystem -f flist.f -o tb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^STATUS: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int DEPTH          = 256;
    localparam int MEM_BYTES      = DEPTH * 4;
    localparam int TIMEOUT_CYCLES = 4000;

    logic               clk;
    logic               rst_n_i;
    logic               flush_i;
    logic               in_valid_i;
    logic               in_ready_o;
    mem_pkg::mem_op_t   in_op_i;
    mem_pkg::word_t     in_addr_i;
    mem_pkg::word_t     in_store_data_i;
    mem_pkg::word_t     in_pc_i;
    mem_pkg::reg_idx_t  in_wreg_idx_i;
    logic               in_wreg_en_i;
    logic               wb_valid_o;
    logic               wb_ready_i;
    logic               wb_we_o;
    mem_pkg::reg_idx_t  wb_idx_o;
    mem_pkg::word_t     wb_data_o;
    mem_pkg::word_t     wb_pc_o;

    // reference memory, byte addressed
    mem_pkg::byte_t     ref_mem [MEM_BYTES];
    mem_pkg::word_t     exp_data [$];
    mem_pkg::word_t     exp_pc [$];
    mem_pkg::reg_idx_t  exp_idx [$];
    logic               exp_we [$];
    logic [31:0]        lfsr_state;
    mem_pkg::word_t     pc_seq;
    logic               ready_pat [256];
    logic               use_pat;
    logic               ready_level;
    int                 cycle_cnt;
    int                 err_cnt;
    int                 tests_passed;
    int                 tests_failed;

    mem_subsystem_top #(
        .DEPTH_WORDS (DEPTH)
    ) u_mem_subsystem_top (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .in_op_i         (in_op_i),
        .in_addr_i       (in_addr_i),
        .in_store_data_i (in_store_data_i),
        .in_pc_i         (in_pc_i),
        .in_wreg_idx_i   (in_wreg_idx_i),
        .in_wreg_en_i    (in_wreg_en_i),
        .wb_valid_o      (wb_valid_o),
        .wb_ready_i      (wb_ready_i),
        .wb_we_o         (wb_we_o),
        .wb_idx_o        (wb_idx_o),
        .wb_data_o       (wb_data_o),
        .wb_pc_o         (wb_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // random back-pressure follows a pattern indexed by cycle
    always @(posedge clk) begin
        cycle_cnt  <= cycle_cnt + 1;
        wb_ready_i <= use_pat ? ready_pat[cycle_cnt[7:0]] : ready_level;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic mem_pkg::word_t take_bits(input int n);
        mem_pkg::word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic mem_pkg::word_t next_pc();
        pc_seq = pc_seq + 32'd4;
        return pc_seq;
    endfunction

    function automatic mem_pkg::mem_op_t make_op(input logic store, input logic uns,
                                                 input int size);
        mem_pkg::mem_op_t op;
        op = '0;
        op[mem_pkg::MEM_OP_EN]  = 1'b1;
        op[mem_pkg::MEM_OP_ST]  = store;
        op[mem_pkg::MEM_OP_UNS] = uns;
        op[mem_pkg::MEM_OP_W]   = (size == 4);
        op[mem_pkg::MEM_OP_H]   = (size == 2);
        op[mem_pkg::MEM_OP_B]   = (size == 1);
        return op;
    endfunction

    task automatic check_value(input string name, input mem_pkg::word_t exp,
                               input mem_pkg::word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // model update for the item on the inputs, called at its accept
    task automatic book_item();
        int a;
        int n;
        mem_pkg::word_t val;
        n = in_op_i[mem_pkg::MEM_OP_W] ? 4 : (in_op_i[mem_pkg::MEM_OP_H] ? 2 : 1);
        a = in_addr_i % MEM_BYTES;
        a = a - a % n;
        val = in_addr_i;
        if (in_op_i[mem_pkg::MEM_OP_EN] && in_op_i[mem_pkg::MEM_OP_ST]) begin
            for (int i = 0; i < n; i++) begin
                ref_mem[a + i] = in_store_data_i[8*i +: 8];
            end
        end else if (in_op_i[mem_pkg::MEM_OP_EN]) begin
            val = '0;
            for (int i = n - 1; i >= 0; i--) begin
                val = {val[23:0], ref_mem[a + i]};
            end
            if (!in_op_i[mem_pkg::MEM_OP_UNS] && n == 1) begin
                val = {{24{val[7]}}, val[7:0]};
            end
            if (!in_op_i[mem_pkg::MEM_OP_UNS] && n == 2) begin
                val = {{16{val[15]}}, val[15:0]};
            end
        end
        exp_data.push_back(val);
        exp_pc.push_back(in_pc_i);
        exp_idx.push_back(in_wreg_idx_i);
        exp_we.push_back(in_wreg_en_i && in_wreg_idx_i != 5'd0);
    endtask

    task automatic drive_item(input mem_pkg::mem_op_t op, input mem_pkg::word_t addr,
                              input mem_pkg::word_t sdata, input mem_pkg::reg_idx_t idx,
                              input logic wen);
        @(posedge clk);
        in_valid_i      <= 1'b1;
        in_op_i         <= op;
        in_addr_i       <= addr;
        in_store_data_i <= sdata;
        in_pc_i         <= next_pc();
        in_wreg_idx_i   <= idx;
        in_wreg_en_i    <= wen;
    endtask

    // ends at the negedge before the accepting edge
    task automatic wait_accept();
        @(negedge clk);
        while (!in_ready_o) begin
            @(negedge clk);
        end
        book_item();
    endtask

    task automatic send_item(input mem_pkg::mem_op_t op, input mem_pkg::word_t addr,
                             input mem_pkg::word_t sdata, input mem_pkg::reg_idx_t idx,
                             input logic wen);
        drive_item(op, addr, sdata, idx, wen);
        wait_accept();
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid_i <= 1'b0;
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    // a transfer happens on the next edge when valid and ready are both high here
    always @(negedge clk) begin : watch_output
        mem_pkg::word_t exp_d;
        mem_pkg::word_t exp_p;
        mem_pkg::reg_idx_t exp_i;
        logic exp_w;
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            if (exp_data.size() == 0) begin
                $display("unexpected writeback output with data %h pc %h", wb_data_o, wb_pc_o);
                err_cnt++;
            end else begin
                exp_d = exp_data.pop_front();
                exp_p = exp_pc.pop_front();
                exp_i = exp_idx.pop_front();
                exp_w = exp_we.pop_front();
                check_value("wb_data_o", exp_d, wb_data_o);
                check_value("wb_pc_o", exp_p, wb_pc_o);
                check_value("wb_idx_o", {27'b0, exp_i}, {27'b0, wb_idx_o});
                check_value("wb_we_o", {31'b0, exp_w}, {31'b0, wb_we_o});
            end
        end
    end

    task automatic test_reset_state();
        int errs;
        errs = err_cnt;
        @(negedge clk);
        check_value("wb_valid_o", 32'd0, {31'b0, wb_valid_o});
        check_value("wb_we_o", 32'd0, {31'b0, wb_we_o});
        check_value("dmem req", 32'd0, {31'b0, u_mem_subsystem_top.u_dmem_if.req});
        check_value("dmem ack", 32'd0, {28'b0, u_mem_subsystem_top.u_dmem_if.ack});
        report_test("reset_state", errs);
    endtask

    task automatic test_word_access();
        int errs;
        mem_pkg::word_t addrs [4];
        errs = err_cnt;
        addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_03fc};
        for (int i = 0; i < 4; i++) begin
            send_item(make_op(1'b1, 1'b0, 4), addrs[i], take_bits(32), 5'(i + 1), 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            send_item(make_op(1'b0, 1'b0, 4), addrs[i], '0, 5'(i + 1), 1'b1);
        end
        drain();
        report_test("word_access", errs);
    endtask

    task automatic test_sub_word();
        int errs;
        mem_pkg::byte_t bvals [4];
        errs = err_cnt;
        bvals = '{8'h7f, 8'h80, 8'h01, 8'hfe};
        send_item(make_op(1'b1, 1'b0, 4), 32'h80, 32'h1122_3344, 5'd0, 1'b0);
        for (int off = 0; off < 4; off++) begin
            send_item(make_op(1'b1, 1'b0, 1), 32'h80 + off, {24'h0, bvals[off]}, 5'd0, 1'b0);
            send_item(make_op(1'b0, 1'b0, 4), 32'h80, '0, 5'd2, 1'b1);
        end
        for (int off = 0; off < 4; off++) begin
            send_item(make_op(1'b0, 1'b0, 1), 32'h80 + off, '0, 5'd3, 1'b1);
            send_item(make_op(1'b0, 1'b1, 1), 32'h80 + off, '0, 5'd4, 1'b1);
        end
        send_item(make_op(1'b1, 1'b0, 4), 32'h84, 32'hdead_beef, 5'd0, 1'b0);
        send_item(make_op(1'b1, 1'b0, 2), 32'h84, 32'h0000_8001, 5'd0, 1'b0);
        send_item(make_op(1'b0, 1'b0, 4), 32'h84, '0, 5'd5, 1'b1);
        send_item(make_op(1'b1, 1'b0, 2), 32'h86, 32'h0000_7ffe, 5'd0, 1'b0);
        send_item(make_op(1'b0, 1'b0, 4), 32'h84, '0, 5'd5, 1'b1);
        for (int off = 0; off < 4; off += 2) begin
            send_item(make_op(1'b0, 1'b0, 2), 32'h84 + off, '0, 5'd6, 1'b1);
            send_item(make_op(1'b0, 1'b1, 2), 32'h84 + off, '0, 5'd7, 1'b1);
        end
        drain();
        report_test("sub_word", errs);
    endtask

    task automatic test_alu_items();
        int errs;
        mem_pkg::word_t r;
        errs = err_cnt;
        for (int i = 0; i < 8; i++) begin
            r = take_bits(5);
            // index 0 on some items, write enable still set
            if (i % 4 == 0) begin
                r = '0;
            end
            send_item('0, take_bits(32), 32'hffff_ffff, r[4:0], 1'b1);
        end
        drain();
        report_test("alu_items", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = err_cnt;
        ready_level = 1'b0;
        send_item('0, 32'h0000_1111, '0, 5'd1, 1'b1);
        send_item(make_op(1'b0, 1'b0, 4), 32'h0000_0100, '0, 5'd2, 1'b1);
        drive_item('0, 32'h0000_3333, '0, 5'd3, 1'b1);
        repeat (6) begin
            @(negedge clk);
            check_value("in_ready_o", 32'd0, {31'b0, in_ready_o});
            check_value("wb_valid_o", 32'd1, {31'b0, wb_valid_o});
            check_value("wb_data_o", exp_data[0], wb_data_o);
            check_value("wb_pc_o", exp_pc[0], wb_pc_o);
        end
        ready_level = 1'b1;
        wait_accept();
        drain();
        report_test("back_pressure", errs);
    endtask

    task automatic test_flush();
        int errs;
        errs = err_cnt;
        send_item(make_op(1'b1, 1'b0, 4), 32'h140, 32'h0bad_f00d, 5'd0, 1'b0);
        drain();
        drive_item(make_op(1'b0, 1'b0, 4), 32'h140, '0, 5'd9, 1'b1);
        @(negedge clk);
        if (in_ready_o) begin
            $display("load was accepted before its bank acknowledge");
            err_cnt++;
        end
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i    <= 1'b0;
        in_valid_i <= 1'b0;
        repeat (5) begin
            @(negedge clk);
            if (wb_valid_o) begin
                $display("flushed load reached the writeback outputs");
                err_cnt++;
            end
        end
        send_item(make_op(1'b1, 1'b0, 1), 32'h141, 32'h0000_00c3, 5'd0, 1'b0);
        send_item(make_op(1'b0, 1'b0, 4), 32'h140, '0, 5'd10, 1'b1);
        drain();
        report_test("flush", errs);
    endtask

    task automatic test_random_ops();
        int errs;
        int size;
        mem_pkg::word_t kind;
        mem_pkg::word_t sel;
        mem_pkg::word_t off;
        mem_pkg::word_t addr;
        mem_pkg::word_t idx;
        errs = err_cnt;
        // known contents for the window the random loads use
        for (int w = 0; w < 16; w++) begin
            send_item(make_op(1'b1, 1'b0, 4), 32'h200 + 4 * w, take_bits(32), 5'd0, 1'b0);
        end
        for (int i = 0; i < 256; i++) begin
            sel = take_bits(1);
            ready_pat[i] = sel[0];
        end
        use_pat = 1'b1;
        for (int i = 0; i < 60; i++) begin
            kind = take_bits(2);
            sel  = take_bits(2) % 3;
            size = (sel == 0) ? 1 : ((sel == 1) ? 2 : 4);
            off  = take_bits(2);
            off  = off - off % size;
            addr = 32'h200 + 4 * take_bits(4) + off;
            idx  = take_bits(5);
            if (kind == 0) begin
                send_item('0, take_bits(32), '0, idx[4:0], take_bits(1) != 0);
            end else begin
                sel = take_bits(1);
                send_item(make_op(kind == 1, sel[0], size), addr, take_bits(32), idx[4:0],
                          take_bits(1) != 0);
            end
        end
        use_pat = 1'b0;
        drain();
        report_test("random_ops", errs);
    endtask

    initial begin
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        in_valid_i      = 1'b0;
        in_op_i         = '0;
        in_addr_i       = '0;
        in_store_data_i = '0;
        in_pc_i         = '0;
        in_wreg_idx_i   = '0;
        in_wreg_en_i    = 1'b0;
        wb_ready_i      = 1'b1;
        ready_level     = 1'b1;
        use_pat         = 1'b0;
        lfsr_state      = 32'h517d;
        pc_seq          = 32'h0000_1000;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset_state();
        test_word_access();
        test_sub_word();
        test_alu_items();
        test_back_pressure();
        test_flush();
        test_random_ops();
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  mem_pkg::word_t       in_result_i,
    input  mem_pkg::word_t       in_pc_i,
    input  mem_pkg::reg_idx_t    in_wreg_idx_i,
    input  logic                 in_wreg_en_i,

    output logic                 wb_valid_o,
    input  logic                 wb_ready_i,
    output logic                 wb_we_o,
    output mem_pkg::reg_idx_t    wb_idx_o,
    output mem_pkg::word_t       wb_data_o,
    output mem_pkg::word_t       wb_pc_o
);

    logic               valid_q;
    logic               we_q;
    mem_pkg::word_t     data_q;
    mem_pkg::word_t     pc_q;
    mem_pkg::reg_idx_t  idx_q;
    logic               load;

    // empty or draining this cycle
    assign in_ready_o = ~valid_q | wb_ready_i;
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
            // x0 is hardwired, never written
            we_q    <= in_wreg_en_i & (|in_wreg_idx_i);
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_result_i;
            pc_q   <= in_pc_i;
            idx_q  <= in_wreg_idx_i;
        end
    end

    assign wb_valid_o = valid_q;
    assign wb_we_o    = valid_q & we_q;
    assign wb_idx_o   = idx_q;
    assign wb_data_o  = data_q;
    assign wb_pc_o    = pc_q;

endmodule
